// File: Bender.yml
package:
  name: sd_dma

sources:
  - include_dirs:
      - source
    files:
      - source/sd_bus_pkg.sv
      - source/sram_pkg.sv
      - source/sd_dma.sv
      - source/sd_crc16_check.sv
      - source/sram_block_buffer.sv
      - source/sd_dma_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/sd_dma_assertions.sv
      - testbench/sd_dma_tb.sv

// File: source/sd_bus_pkg.sv
`default_nettype none

package sd_bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // SD card side
  //////////////////////////////////////////////////////////////////////

  // DAT[3:0] sampled together, bit i is line i
  typedef logic [3:0] sd_nibble_t;

  // Host visible transfer status
  typedef struct packed {
    // Transfer in progress
    logic busy;
    // One-cycle end of block
    logic done;
    // Any line CRC mismatch, held until next start
    logic crc_error;
  } sd_status_t;

endpackage

`default_nettype wire

// File: source/sd_crc16_check.sv
`timescale 1ns/10ps
`default_nettype none

module sd_crc16_check
  import sd_bus_pkg::*;
(
  input  wire        CLK,
  input  wire        arst_n,
  input  wire        restart,
  input  wire        sample_en,
  input  wire        crc_phase,
  input  wire        frame_end,
  input  wire        sd_nibble_t sample,
  output logic       crc_error
);

  // CCITT x^16+x^12+x^5+1
  localparam logic [15:0] POLY = 16'h1021;

  logic [3:0][15:0] crc_q;
  logic [3:0][15:0] rx_q;
  logic             mismatch;

  // One serial step, MSB first
  function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic din);
    logic fb;
    fb = crc[15] ^ din;
    return {crc[14:0], 1'b0} ^ (fb ? POLY : 16'h0000);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Per line CRC and received CRC shift registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      crc_q <= '0;
      rx_q  <= '0;
    end else if (restart) begin
      crc_q <= '0;
      rx_q  <= '0;
    end else if (sample_en) begin
      for (int i = 0; i < 4; i++) begin
        if (crc_phase) begin
          // Card sends its CRC MSB first
          rx_q[i] <= {rx_q[i][14:0], sample[i]};
        end else begin
          crc_q[i] <= crc16_step(crc_q[i], sample[i]);
        end
      end
    end
  end

  always_comb begin
    mismatch = 1'b0;
    for (int i = 0; i < 4; i++) begin
      mismatch = mismatch | (crc_q[i] != rx_q[i]);
    end
  end

  // Valid from frame end until next restart
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      crc_error <= 1'b0;
    end else if (restart) begin
      crc_error <= 1'b0;
    end else if (frame_end) begin
      crc_error <= mismatch;
    end
  end

endmodule

`default_nettype wire

// File: source/sd_dma.sv
`timescale 1ns/10ps
`default_nettype none

`include "sd_dma_defs.svh"

module sd_dma
  import sd_bus_pkg::*;
  import sram_pkg::*;
(
  input  wire        CLK,
  input  wire        arst_n,
  input  wire        start,
  input  wire        sd_nibble_t sd_dat,
  output logic       sd_clk,
  output logic       sd_clk_oe,
  output logic       busy,
  output logic       done,
  output sram_wr_t   wr,
  output logic       crc_restart,
  output logic       crc_sample,
  output logic       crc_phase,
  output logic       frame_end,
  output sd_nibble_t sample
);

  localparam int CYC_W = $clog2(`SD_FRAME_CYCLES);
  localparam int DIV_W = $clog2(`SD_CLK_DIV);
  localparam logic [DIV_W-1:0] PH_LAST   = DIV_W'(`SD_CLK_DIV - 1);
  localparam logic [CYC_W-1:0] CYC_LAST  = CYC_W'(`SD_FRAME_CYCLES - 1);
  localparam logic [CYC_W-1:0] DATA_LAST = CYC_W'(`SD_DATA_NIBBLES);
  localparam logic [CYC_W-1:0] CRC_LAST  = CYC_W'(`SD_DATA_NIBBLES + `SD_CRC_BITS);

  logic [2:0]       start_sync;
  logic             start_rise;
  logic             go_q;
  logic             busy_q;
  logic             done_q;
  logic [DIV_W-1:0] clk_cnt;
  logic [CYC_W-1:0] cyc_cnt;
  logic             nib_tick;
  logic             last_tick;
  logic             in_data;
  logic             in_crc_win;
  logic [7:0]       byte_q;
  logic             we_q;
  logic             next_q;

  //////////////////////////////////////////////////////////////////////
  // Start detection and transfer control
  //////////////////////////////////////////////////////////////////////

  // Two sync flops plus one history flop for the edge
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      start_sync <= '0;
    end else begin
      start_sync <= {start_sync[1:0], start};
    end
  end

  assign start_rise = start_sync[1] & ~start_sync[2];

  // Edge while busy is dropped
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      go_q   <= 1'b0;
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      go_q   <= start_rise & ~busy_q;
      done_q <= last_tick;
      if (go_q) begin
        busy_q <= 1'b1;
      end else if (last_tick) begin
        busy_q <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // SD clock divider and frame cycle counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      clk_cnt <= '0;
      cyc_cnt <= '0;
    end else if (go_q) begin
      clk_cnt <= '0;
      cyc_cnt <= '0;
    end else if (busy_q) begin
      if (clk_cnt == PH_LAST) begin
        clk_cnt <= '0;
        cyc_cnt <= cyc_cnt + 1'b1;
      end else begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
  end

  // Sample mid high phase, card moves on the falling edge
  assign nib_tick   = busy_q && (clk_cnt == '0);
  assign last_tick  = busy_q && (clk_cnt == PH_LAST) && (cyc_cnt == CYC_LAST);
  // Cycle 0 is the start bit
  assign in_data    = (cyc_cnt != '0) && (cyc_cnt <= DATA_LAST);
  assign in_crc_win = (cyc_cnt != '0) && (cyc_cnt <= CRC_LAST);

  //////////////////////////////////////////////////////////////////////
  // Byte assembly and buffer writes
  //////////////////////////////////////////////////////////////////////

  // Odd cycles carry the high nibble
  always_ff @(posedge CLK) begin
    if (nib_tick && in_data) begin
      if (cyc_cnt[0]) begin
        byte_q[7:4] <= sd_dat;
      end else begin
        byte_q[3:0] <= sd_dat;
      end
    end
  end

  // Strobe spans phases 1 and 2, next_addr sits in phase 2
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      we_q   <= 1'b0;
      next_q <= 1'b0;
    end else if (go_q) begin
      we_q   <= 1'b0;
      next_q <= 1'b0;
    end else begin
      next_q <= we_q && (clk_cnt == DIV_W'(1));
      if (nib_tick && in_data && !cyc_cnt[0]) begin
        we_q <= 1'b1;
      end else if (next_q) begin
        we_q <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////////////////////////

  assign busy      = busy_q;
  assign done      = done_q;
  assign sd_clk_oe = busy_q;
  // High for the first half of each divider period
  assign sd_clk    = busy_q & ~clk_cnt[DIV_W-1];
  assign wr        = '{we: we_q, next_addr: next_q, data: byte_q};

  // CRC side: data cycles then the 16 CRC cycles
  assign crc_restart = go_q;
  assign crc_sample  = nib_tick && in_crc_win;
  assign crc_phase   = cyc_cnt > DATA_LAST;
  assign frame_end   = last_tick;
  assign sample      = sd_dat;

endmodule

`default_nettype wire

// File: source/sd_dma_defs.svh
`ifndef SD_DMA_DEFS_SVH
`define SD_DMA_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// SD block framing
//////////////////////////////////////////////////////////////////////

// Bytes in one SD data block
`define SD_BLOCK_BYTES 512
// CLK cycles per SD clock period
`define SD_CLK_DIV 4
// Nibbles on the 4-bit bus per block
`define SD_DATA_NIBBLES 1024
// CRC-16 bits per data line
`define SD_CRC_BITS 16
// Start bit + data + CRC + stop bit
`define SD_FRAME_CYCLES 1042

// Block buffer address width
`define SRAM_AW 9

`endif

// File: source/sd_dma_top.sv
`timescale 1ns/10ps
`default_nettype none

module sd_dma_top
  import sd_bus_pkg::*;
  import sram_pkg::*;
(
  input  wire        CLK,
  input  wire        arst_n,
  input  wire        start,
  input  wire        sd_nibble_t sd_dat,
  input  wire        sram_addr_t rd_addr,
  output logic       sd_clk,
  output logic       sd_clk_oe,
  output sd_status_t status,
  output logic [7:0] rd_data
);

  logic       busy;
  logic       done;
  logic       crc_error;
  sram_wr_t   wr;
  logic       crc_restart;
  logic       crc_sample;
  logic       crc_phase;
  logic       frame_end;
  sd_nibble_t sample;

  // Transfer engine
  sd_dma u_dma (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .start       (start),
    .sd_dat      (sd_dat),
    .sd_clk      (sd_clk),
    .sd_clk_oe   (sd_clk_oe),
    .busy        (busy),
    .done        (done),
    .wr          (wr),
    .crc_restart (crc_restart),
    .crc_sample  (crc_sample),
    .crc_phase   (crc_phase),
    .frame_end   (frame_end),
    .sample      (sample)
  );

  sd_crc16_check u_crc (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .restart   (crc_restart),
    .sample_en (crc_sample),
    .crc_phase (crc_phase),
    .frame_end (frame_end),
    .sample    (sample),
    .crc_error (crc_error)
  );

  // Same start pulse rewinds the buffer address
  sram_block_buffer u_buf (
    .CLK     (CLK),
    .arst_n  (arst_n),
    .clear   (crc_restart),
    .wr      (wr),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  assign status = '{busy: busy, done: done, crc_error: crc_error};

endmodule

`default_nettype wire

// File: source/sram_block_buffer.sv
`timescale 1ns/10ps
`default_nettype none

`include "sd_dma_defs.svh"

module sram_block_buffer
  import sram_pkg::*;
(
  input  wire        CLK,
  input  wire        arst_n,
  input  wire        clear,
  input  wire        sram_wr_t wr,
  input  wire        sram_addr_t rd_addr,
  output logic [7:0] rd_data
);

  sram_addr_t wr_addr;
  logic       we_d;
  logic       we_rise;
  logic [7:0] mem [`SD_BLOCK_BYTES];

  //////////////////////////////////////////////////////////////////////
  // Write address and strobe edge
  //////////////////////////////////////////////////////////////////////

  // Back to address 0 at every transfer start
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      wr_addr <= '0;
    end else if (clear) begin
      wr_addr <= '0;
    end else if (wr.next_addr) begin
      wr_addr <= wr_addr + 1'b1;
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      we_d <= 1'b0;
    end else begin
      we_d <= wr.we;
    end
  end

  // Strobe is two cycles wide, write once on its first cycle
  assign we_rise = wr.we & ~we_d;

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (we_rise) begin
      mem[wr_addr] <= wr.data;
    end
  end

  // Host read, combinational
  assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

// File: source/sram_pkg.sv
`default_nettype none

`include "sd_dma_defs.svh"

package sram_pkg;

  // Byte address into the block buffer
  typedef logic [`SRAM_AW-1:0] sram_addr_t;

  // Engine to buffer write command
  typedef struct packed {
    // Write strobe, active high, two cycles wide
    logic       we;
    // Advance write address after this byte
    logic       next_addr;
    logic [7:0] data;
  } sram_wr_t;

endpackage

`default_nettype wire

// File: sources.f
+incdir+source
source/sd_bus_pkg.sv
source/sram_pkg.sv
source/sd_dma.sv
source/sd_crc16_check.sv
source/sram_block_buffer.sv
source/sd_dma_top.sv
testbench/sd_dma_assertions.sv
testbench/sd_dma_tb.sv

// File: testbench/sd_dma_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module sd_dma_assertions
  import sd_bus_pkg::*;
  import sram_pkg::*;
(
  input wire             CLK,
  input wire             arst_n,
  input wire             start,
  input wire             sd_clk_oe,
  input wire sd_status_t status,
  input wire sram_wr_t   wr
);

  // Count of failed properties
  int fail_count = 0;

  //////////////////////////////////////////////////////////////////////
  // Top-level protocol
  //////////////////////////////////////////////////////////////////////

  // Clock enable tracks the transfer
  a_oe_busy: assert property (@(posedge CLK) disable iff (!arst_n)
    sd_clk_oe == status.busy)
    else begin
      fail_count++;
      $error("sd_clk_oe differs from busy");
    end

  // Done is a single cycle
  a_done_single: assert property (@(posedge CLK) disable iff (!arst_n)
    status.done |=> !status.done)
    else begin
      fail_count++;
      $error("done longer than one cycle");
    end

  // Done and busy falling go together
  a_done_busy_fall: assert property (@(posedge CLK) disable iff (!arst_n)
    status.done |-> $fell(status.busy))
    else begin
      fail_count++;
      $error("done without busy falling");
    end

  a_busy_fall_done: assert property (@(posedge CLK) disable iff (!arst_n)
    $fell(status.busy) |-> status.done)
    else begin
      fail_count++;
      $error("busy fell without done");
    end

  // Writes only inside a transfer
  a_we_busy: assert property (@(posedge CLK) disable iff (!arst_n)
    wr.we |-> status.busy)
    else begin
      fail_count++;
      $error("write strobe while not busy");
    end

  // Idle start edge never comes with done
  a_no_done_on_edge: assert property (@(posedge CLK) disable iff (!arst_n)
    (!status.busy && $rose(start)) |-> !status.done)
    else begin
      fail_count++;
      $error("done during start edge detection");
    end

endmodule

bind sd_dma_top sd_dma_assertions u_checks (
  .CLK       (CLK),
  .arst_n    (arst_n),
  .start     (start),
  .sd_clk_oe (sd_clk_oe),
  .status    (status),
  .wr        (wr)
);

`default_nettype wire

// File: testbench/sd_dma_patterns.txt
# kind: 0 incrementing, 1 constant (seed is the byte), 2 random from seed 64
# kind seed corrupt_line(-1 none) expected_crc_error
0 0 -1 0
1 165 -1 0
2 0 -1 0
0 0 2 1
2 0 -1 0
1 0 0 1
1 255 -1 0
2 0 3 1
0 0 1 1
0 0 -1 0

// File: testbench/sd_dma_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "sd_dma_defs.svh"

module sd_dma_tb
  import sd_bus_pkg::*;
  import sram_pkg::*;
();

  // Longest wait for done, whole frame plus margin
  localparam int DONE_LIMIT = `SD_FRAME_CYCLES * `SD_CLK_DIV + 100;
  localparam int BUSY_LIMIT = 10;

  logic       CLK;
  logic       arst_n;
  logic       start;
  sd_nibble_t sd_dat;
  sram_addr_t rd_addr;
  logic       sd_clk;
  logic       sd_clk_oe;
  sd_status_t status;
  logic [7:0] rd_data;

  // Expected block and the frame the card sends
  logic [7:0]       block_bytes [`SD_BLOCK_BYTES];
  sd_nibble_t       frame [`SD_FRAME_CYCLES];
  int               frame_idx;
  logic             card_active;
  logic             last_sd_clk;

  int               err_count;
  int               timeout_count;
  int               assert_count;
  int               block_num;
  integer           seed;
  int               fd;
  int               nread;
  int               kind;
  int               value;
  int               corrupt;
  int               exp_err;
  logic [8*128-1:0] line_buf;

  sd_dma_top dut0 (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .start     (start),
    .sd_dat    (sd_dat),
    .rd_addr   (rd_addr),
    .sd_clk    (sd_clk),
    .sd_clk_oe (sd_clk_oe),
    .status    (status),
    .rd_data   (rd_data)
  );

  always #5 CLK = ~CLK;

  //////////////////////////////////////////////////////////////////////
  // SD card model
  //////////////////////////////////////////////////////////////////////

  // Start bit once the clock is enabled, next symbol after each falling sd_clk
  always @(negedge CLK) begin
    if (!sd_clk_oe) begin
      card_active = 1'b0;
    end else if (!card_active) begin
      card_active = 1'b1;
      frame_idx = 0;
      sd_dat = frame[0];
    end else if (last_sd_clk && !sd_clk) begin
      frame_idx = frame_idx + 1;
      // Bus idles high past the stop bit
      sd_dat = (frame_idx < `SD_FRAME_CYCLES) ? frame[frame_idx] : 4'hF;
    end
    last_sd_clk = sd_clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic expect_equal(input int got, input int exp, input string what);
    assert (got == exp) else begin
      err_count++;
      $display("FAILED at %0d ns: %s, got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // Kind 0 incrementing, 1 constant value, 2 random
  task automatic build_frame(input int data_kind, input int data_value, input int bad_lane);
    logic [15:0] c;
    logic        fb;
    for (int b = 0; b < `SD_BLOCK_BYTES; b++) begin
      case (data_kind)
        0:       block_bytes[b] = 8'(b);
        1:       block_bytes[b] = 8'(data_value);
        default: block_bytes[b] = 8'($random(seed));
      endcase
    end
    frame[0] = 4'h0;
    // High nibble of each byte goes first
    for (int k = 0; k < `SD_DATA_NIBBLES; k++) begin
      frame[1 + k] = k[0] ? block_bytes[k / 2][3:0] : block_bytes[k / 2][7:4];
    end
    // CRC-16 CCITT per lane, taps at bits 0, 5 and 12
    for (int lane = 0; lane < 4; lane++) begin
      c = '0;
      for (int k = 1; k <= `SD_DATA_NIBBLES; k++) begin
        fb = c[15] ^ frame[k][lane];
        c = {c[14:0], fb};
        c[5] = c[5] ^ fb;
        c[12] = c[12] ^ fb;
      end
      if (lane == bad_lane) begin
        c[0] = ~c[0];
      end
      // MSB first on the line
      for (int j = 0; j < `SD_CRC_BITS; j++) begin
        frame[1 + `SD_DATA_NIBBLES + j][lane] = c[15 - j];
      end
    end
    frame[`SD_FRAME_CYCLES - 1] = 4'hF;
  endtask

  task automatic read_back();
    for (int a = 0; a < `SD_BLOCK_BYTES; a++) begin
      @(negedge CLK);
      rd_addr = sram_addr_t'(a);
      @(posedge CLK);
      expect_equal(rd_data, block_bytes[a], $sformatf("rd_data at address %0d", a));
    end
  endtask

  task automatic run_block(input int data_kind, input int data_value, input int bad_lane,
                           input int crc_exp);
    int   n;
    int   extra_done;
    int   clk_high;
    int   clk_rises;
    logic clk_prev;
    build_frame(data_kind, data_value, bad_lane);
    @(negedge CLK);
    start = 1'b1;
    n = 0;
    while (!status.busy && n < BUSY_LIMIT) begin
      @(negedge CLK);
      n++;
    end
    if (!status.busy) begin
      $display("timeout waiting for busy in block %0d", block_num);
      timeout_count++;
      return;
    end
    // Two sync stages, edge flop, then busy
    expect_equal(n, 4, "busy latency after start");
    expect_equal(status.crc_error, 0, "crc_error cleared by start");
    n = 0;
    clk_high = 0;
    clk_rises = 0;
    clk_prev = 1'b0;
    while (!status.done && n < DONE_LIMIT) begin
      expect_equal(status.busy, 1, "busy before done");
      // SD clock level and edges over the frame
      if (sd_clk) begin
        clk_high++;
      end
      if (sd_clk && !clk_prev) begin
        clk_rises++;
      end
      clk_prev = sd_clk;
      // Second rising edge during the transfer
      if (n == 200) begin
        start = 1'b0;
      end
      if (n == 204) begin
        start = 1'b1;
      end
      @(negedge CLK);
      n++;
    end
    if (!status.done) begin
      $display("timeout waiting for done in block %0d", block_num);
      timeout_count++;
      return;
    end
    expect_equal(status.busy, 0, "busy low in the done cycle");
    expect_equal(status.crc_error, crc_exp, "crc_error at done");
    expect_equal(clk_rises, `SD_FRAME_CYCLES, "sd_clk periods in one frame");
    expect_equal(clk_high, `SD_CLK_DIV / 2 * `SD_FRAME_CYCLES,
                 "sd_clk high cycles in one frame");
    // Start still high, nothing may follow
    extra_done = 0;
    for (int i = 0; i < 100; i++) begin
      @(negedge CLK);
      expect_equal(status.busy, 0, "busy with start held high");
      if (status.done) begin
        extra_done++;
      end
    end
    expect_equal(extra_done, 0, "done pulses after the first");
    expect_equal(status.crc_error, crc_exp, "crc_error held after done");
    start = 1'b0;
    read_back();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    CLK = 1'b0;
    arst_n = 1'b0;
    start = 1'b0;
    sd_dat = 4'hF;
    rd_addr = '0;
    card_active = 1'b0;
    last_sd_clk = 1'b0;
    frame_idx = 0;
    err_count = 0;
    timeout_count = 0;
    assert_count = 0;
    block_num = 0;
    seed = 64;
    repeat (8) @(negedge CLK);
    arst_n = 1'b1;

    // Idle after reset
    for (int i = 0; i < 20; i++) begin
      @(negedge CLK);
      expect_equal(int'(status), 0, "status after reset");
      expect_equal(sd_clk_oe, 0, "sd_clk_oe after reset");
    end

    fd = $fopen("testbench/sd_dma_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/sd_dma_patterns.txt");
      err_count++;
    end else begin
      while (!$feof(fd) && timeout_count == 0) begin
        line_buf = '0;
        nread = $fgets(line_buf, fd);
        // Comment and blank lines do not parse
        if (nread > 0 &&
            $sscanf(line_buf, "%d %d %d %d", kind, value, corrupt, exp_err) == 4) begin
          block_num++;
          run_block(kind, value, corrupt, exp_err);
        end
      end
      $fclose(fd);
    end
    if (block_num == 0) begin
      $display("no test blocks were read from the pattern file");
      err_count++;
    end

    assert_count = dut0.u_checks.fail_count;
    $display("blocks: %0d, check errors: %0d, timeouts: %0d, assertion failures: %0d",
             block_num, err_count, timeout_count, assert_count);
    if (err_count == 0 && timeout_count == 0 && assert_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
